//--- common/sens_io_pkg.sv
// Shared types and constants for the parallel sensor port.
// Holds the Wishbone bus structs, the register map, the CTRL/JTAG write
// word views and the config/status structs between control and pads.
// Modules import it inside their body and use scoped names in headers.
`default_nettype none

package sens_io_pkg;

    localparam int SENS_ADDR_BITS      = 2;  // word address, 4 registers
    localparam int SENS_DATA_BITS      = 32;
    localparam int PXD_BITS            = 12; // sensor pixel bus
    localparam int LINE_WIDTH_BITS_DEF = 16; // default line width counter size

    // status word bit positions
    localparam int STAT_TDO_BIT       = 0;
    localparam int STAT_SENSPGM_BIT   = 1;
    localparam int STAT_DONE_BIT      = 2;
    localparam int STAT_FORCE_PGM_BIT = 3;
    localparam int STAT_PGMEN_BIT     = 4;
    localparam int STAT_INT_HACT_BIT  = 5;

    typedef enum logic [SENS_ADDR_BITS-1:0] {
        REG_CTRL   = 2'd0,
        REG_STATUS = 2'd1,
        REG_JTAG   = 2'd2,
        REG_WIDTH  = 2'd3
    } sens_reg_e;

    typedef struct packed {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        logic [SENS_ADDR_BITS-1:0] adr; // word address
        logic [SENS_DATA_BITS-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                      ack;
        logic [SENS_DATA_BITS-1:0] dat;
    } wb_rsp_t;

    // one set/clear pair, value loads only with en
    typedef struct packed {
        logic en;
        logic val;
    } set_pair_t;

    typedef struct packed {
        logic [25:0] rsvd;
        set_pair_t   aro;  // 5:4
        set_pair_t   arst; // 3:2
        set_pair_t   mrst; // 1:0
    } ctrl_word_t;

    typedef struct packed {
        logic [21:0] rsvd;
        set_pair_t   pgmen; // 9:8
        set_pair_t   prog;  // 7:6
        set_pair_t   tck;   // 5:4
        set_pair_t   tms;   // 3:2
        set_pair_t   tdi;   // 1:0
    } jtag_word_t;

    // same bus word, decoded by address
    typedef union packed {
        ctrl_word_t                ctrl;
        jtag_word_t                jtag;
        logic [SENS_DATA_BITS-1:0] raw;
    } wr_word_u;

    typedef struct packed {
        logic mrst;
        logic arst;
        logic aro;
        logic pgmen; // external FPGA programming mode
        logic prog;
        logic tck;
        logic tms;
        logic tdi;
    } sens_cfg_t;

    typedef struct packed {
        logic done;       // MRST pad read back
        logic senspgm_in;
        logic tdo;        // pixel bit 1
        logic force_pgm;
    } pad_stat_t;

endpackage

`default_nettype wire

//--- hw/sens_io_ctrl/sens_io_ctrl.sv
// Control registers of the sensor port behind a Wishbone classic slave.
// CTRL and JTAG take set/clear pairs, WIDTH holds the line width for HACT
// regeneration, STATUS returns the sampled pad state and mode flags.
// Every request is acknowledged one cycle after it is first seen.
`timescale 1ns/1ps
`default_nettype none

module sens_io_ctrl #(
    parameter int LINE_WIDTH_BITS = 16
) (
    input  logic                       mclk,
    input  logic                       rst,
    input  sens_io_pkg::wb_req_t       wb_i,
    input  sens_io_pkg::pad_stat_t     pad_stat_i,
    output sens_io_pkg::wb_rsp_t       wb_o,
    output sens_io_pkg::sens_cfg_t     cfg_o,
    output logic [LINE_WIDTH_BITS-1:0] line_width_m1_o,
    output logic                       line_width_internal_o
);
    import sens_io_pkg::*;

    logic                       req;        // cyc & stb
    logic                       acc_en;     // request accepted this cycle
    logic                       wr_en;
    logic                       rd_en;
    logic                       ack_r;
    logic [SENS_DATA_BITS-1:0]  rd_dat_r;
    sens_reg_e                  reg_sel;
    wr_word_u                   wr_word;    // write data, CTRL or JTAG view
    wr_word_u                   rd_word;    // read data being built
    sens_cfg_t                  cfg_r;
    sens_cfg_t                  cfg_nxt;
    logic [LINE_WIDTH_BITS-1:0] wr_width;
    logic [LINE_WIDTH_BITS-1:0] width_rb;   // width read back
    logic [LINE_WIDTH_BITS-1:0] line_width_m1_r;
    logic                       line_width_internal_r;

    // value bit loads only when its enable is set
    function automatic logic apply_pair(input set_pair_t pair, input logic cur);
        return pair.en ? pair.val : cur;
    endfunction

    assign req      = wb_i.cyc & wb_i.stb;
    assign acc_en   = req & ~ack_r;           // no second ack for the same request
    assign wr_en    = acc_en & wb_i.we;
    assign rd_en    = acc_en & ~wb_i.we;
    assign reg_sel  = sens_reg_e'(wb_i.adr);
    assign wr_width = wr_word.raw[LINE_WIDTH_BITS-1:0];

    always_comb begin
        wr_word.raw = wb_i.dat;
    end

    // set/clear update of the register fields picked by address
    always_comb begin
        cfg_nxt = cfg_r;
        if (wr_en) begin
            case (reg_sel)
                REG_CTRL: begin
                    cfg_nxt.mrst = apply_pair(wr_word.ctrl.mrst, cfg_r.mrst);
                    cfg_nxt.arst = apply_pair(wr_word.ctrl.arst, cfg_r.arst);
                    cfg_nxt.aro  = apply_pair(wr_word.ctrl.aro,  cfg_r.aro); // own enable
                end
                REG_JTAG: begin
                    cfg_nxt.pgmen = apply_pair(wr_word.jtag.pgmen, cfg_r.pgmen);
                    cfg_nxt.prog  = apply_pair(wr_word.jtag.prog,  cfg_r.prog);
                    cfg_nxt.tck   = apply_pair(wr_word.jtag.tck,   cfg_r.tck);
                    cfg_nxt.tms   = apply_pair(wr_word.jtag.tms,   cfg_r.tms);
                    cfg_nxt.tdi   = apply_pair(wr_word.jtag.tdi,   cfg_r.tdi);
                end
                default: ; // STATUS is read only, WIDTH handled below
            endcase
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            cfg_r <= '0;
            ack_r <= 1'b0;
        end else begin
            cfg_r <= cfg_nxt;  // lands on the ack edge
            ack_r <= acc_en;   // single cycle ack
        end
    end

    // width is stored as count minus one, zero selects external hact
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            line_width_m1_r       <= '0;
            line_width_internal_r <= 1'b0;
        end else if (wr_en && reg_sel == REG_WIDTH) begin
            line_width_m1_r       <= wr_width - LINE_WIDTH_BITS'(1);
            line_width_internal_r <= |wr_width;
        end
    end

    assign width_rb = line_width_internal_r ? line_width_m1_r + LINE_WIDTH_BITS'(1)
                                            : '0;

    // read word, current state of the addressed register
    always_comb begin
        rd_word.raw = '0;
        case (reg_sel)
            REG_CTRL: begin
                rd_word.ctrl.mrst.val = cfg_r.mrst;
                rd_word.ctrl.arst.val = cfg_r.arst;
                rd_word.ctrl.aro.val  = cfg_r.aro;
            end
            REG_STATUS: begin
                rd_word.raw[STAT_TDO_BIT]       = pad_stat_i.tdo;
                rd_word.raw[STAT_SENSPGM_BIT]   = pad_stat_i.senspgm_in;
                rd_word.raw[STAT_DONE_BIT]      = pad_stat_i.done;
                rd_word.raw[STAT_FORCE_PGM_BIT] = pad_stat_i.force_pgm;
                rd_word.raw[STAT_PGMEN_BIT]     = cfg_r.pgmen;
                rd_word.raw[STAT_INT_HACT_BIT]  = line_width_internal_r;
            end
            REG_JTAG: begin
                rd_word.jtag.pgmen.val = cfg_r.pgmen;
                rd_word.jtag.prog.val  = cfg_r.prog;
                rd_word.jtag.tck.val   = cfg_r.tck;
                rd_word.jtag.tms.val   = cfg_r.tms;
                rd_word.jtag.tdi.val   = cfg_r.tdi;
            end
            REG_WIDTH: begin
                rd_word.raw = SENS_DATA_BITS'(width_rb); // zero extended
            end
            default: ;
        endcase
    end

    // captured at the request cycle, presented with ack
    always_ff @(posedge mclk) begin
        if (rd_en) begin
            rd_dat_r <= rd_word.raw;
        end
    end

    always_comb begin
        wb_o.ack = ack_r;
        wb_o.dat = rd_dat_r;
    end

    assign cfg_o                 = cfg_r;
    assign line_width_m1_o       = line_width_m1_r;
    assign line_width_internal_o = line_width_internal_r;

endmodule

`default_nettype wire

//--- hw/sens_pad_ctrl.sv
// Pad multiplexer between sensor control and external FPGA programming.
// Outputs follow the register state combinationally, inputs are sampled
// once. SENSPGM is probed when programming mode ends and then held.
`timescale 1ns/1ps
`default_nettype none

module sens_pad_ctrl (
    input  logic                   mclk,
    input  logic                   rst,
    input  sens_io_pkg::sens_cfg_t cfg_i,
    input  logic                   trigger_mode_i,
    input  logic                   trig_i,
    input  logic                   mrst_i,       // DONE from external FPGA
    input  logic                   senspgm_i,
    input  logic                   tdo_i,        // pixel bit 1
    output sens_io_pkg::pad_stat_t pad_stat_o,
    output logic                   mrst_o,
    output logic                   mrst_oe_o,
    output logic                   arst_o,
    output logic                   aro_o,
    output logic                   senspgm_o,
    output logic                   senspgm_oe_o,
    output logic                   pxd0_o,
    output logic                   pxd0_oe_o
);

    logic       done_r;
    logic       senspgm_r;
    logic       tdo_r;
    logic [1:0] pgmen_d;     // pgmen history, [1] older
    logic       force_pgm_r; // level held on senspgm after programming

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            done_r    <= 1'b0;
            senspgm_r <= 1'b0;
            tdo_r     <= 1'b0;
            pgmen_d   <= 2'b00;
        end else begin
            done_r    <= mrst_i;
            senspgm_r <= senspgm_i;
            tdo_r     <= tdo_i;
            pgmen_d   <= {pgmen_d[0], cfg_i.pgmen};
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            force_pgm_r <= 1'b0;
        end else if (pgmen_d == 2'b10) begin
            force_pgm_r <= senspgm_r;  // pgmen just fell
        end
    end

    // programming mode takes aro/arst/senspgm/pxd0, mrst turns input
    assign aro_o        = cfg_i.pgmen    ? cfg_i.tck :
                          trigger_mode_i ? ~trig_i   : cfg_i.aro;
    assign arst_o       = cfg_i.pgmen ? cfg_i.tms : cfg_i.arst;
    assign mrst_o       = cfg_i.mrst;
    assign mrst_oe_o    = ~cfg_i.pgmen;  // released to read DONE
    assign senspgm_o    = cfg_i.pgmen ? ~cfg_i.prog : force_pgm_r;
    assign senspgm_oe_o = cfg_i.pgmen | force_pgm_r;
    assign pxd0_o       = cfg_i.tdi;
    assign pxd0_oe_o    = cfg_i.pgmen;

    always_comb begin
        pad_stat_o.done       = done_r;
        pad_stat_o.senspgm_in = senspgm_r;
        pad_stat_o.tdo        = tdo_r;
        pad_stat_o.force_pgm  = force_pgm_r;
    end

endmodule

`default_nettype wire

//--- hw/sens_line_timing.sv
// Pixel and line timing path of the sensor port.
// Pixel data and VACT get one register stage. HACT is either passed
// through with the same delay or regenerated for a programmed width,
// started by each rising edge of the received HACT.
`timescale 1ns/1ps
`default_nettype none

module sens_line_timing #(
    parameter int LINE_WIDTH_BITS = 16
) (
    input  logic                             mclk,
    input  logic                             rst,
    input  logic [sens_io_pkg::PXD_BITS-1:0] pxd_i,
    input  logic                             hact_i,
    input  logic                             vact_i,
    input  logic [LINE_WIDTH_BITS-1:0]       line_width_m1_i,
    input  logic                             line_width_internal_i,
    output logic [sens_io_pkg::PXD_BITS-1:0] pxd_o,
    output logic                             hact_o,
    output logic                             vact_o
);
    import sens_io_pkg::*;

    logic [PXD_BITS-1:0]        pxd_r;
    logic                       vact_r;
    logic                       hact_in_r;  // previous hact_i sample
    logic                       hact_r;     // received or regenerated
    logic                       hact_start;
    logic                       hact_end;
    logic [LINE_WIDTH_BITS-1:0] hact_cntr;  // cycles left in line

    assign hact_start = hact_i & ~hact_in_r;
    // internal mode counts down, external follows the pin
    assign hact_end   = line_width_internal_i ? (hact_cntr == '0) : ~hact_i;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            pxd_r     <= '0;
            vact_r    <= 1'b0;
            hact_in_r <= 1'b0;
        end else begin
            pxd_r     <= pxd_i;   // same stage as hact_r
            vact_r    <= vact_i;
            hact_in_r <= hact_i;
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            hact_r <= 1'b0;
        end else if (hact_start) begin
            hact_r <= 1'b1;       // new line wins over end
        end else if (hact_end) begin
            hact_r <= 1'b0;
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            hact_cntr <= '0;
        end else if (hact_start) begin
            hact_cntr <= line_width_m1_i;
        end else if (hact_r && hact_cntr != '0) begin
            hact_cntr <= hact_cntr - LINE_WIDTH_BITS'(1); // stop at zero
        end
    end

    assign pxd_o  = pxd_r;
    assign vact_o = vact_r;
    assign hact_o = hact_r;

endmodule

`default_nettype wire

//--- hw/sens_parallel_top.sv
// Top level of the parallel sensor port, mclk domain only.
// Connects the Wishbone control block to the pad multiplexer and the
// pixel/line timing path. Pads appear as separate out, enable and in ports.
`timescale 1ns/1ps
`default_nettype none

module sens_parallel_top #(
    parameter int LINE_WIDTH_BITS = sens_io_pkg::LINE_WIDTH_BITS_DEF
) (
    input  logic                            mclk,
    input  logic                            rst,
    input  sens_io_pkg::wb_req_t            wb_i,
    output sens_io_pkg::wb_rsp_t            wb_o,
    input  logic                            trigger_mode_i, // triggered mode, aro from trig
    input  logic                            trig_i,
    input  logic [sens_io_pkg::PXD_BITS-1:0] pxd_i,
    input  logic                            hact_i,
    input  logic                            vact_i,
    input  logic                            mrst_i,         // DONE in programming mode
    input  logic                            senspgm_i,
    output logic [sens_io_pkg::PXD_BITS-1:0] pxd_o,
    output logic                            hact_o,
    output logic                            vact_o,
    output logic                            mrst_o,
    output logic                            mrst_oe_o,
    output logic                            arst_o,
    output logic                            aro_o,
    output logic                            senspgm_o,
    output logic                            senspgm_oe_o,
    output logic                            pxd0_o,         // TDI in programming mode
    output logic                            pxd0_oe_o
);
    import sens_io_pkg::*;

    sens_cfg_t                  cfg;                 // register state to pads
    pad_stat_t                  pad_stat;            // sampled pads to control
    logic [LINE_WIDTH_BITS-1:0] line_width_m1;
    logic                       line_width_internal; // regenerate hact

    sens_io_ctrl #(
        .LINE_WIDTH_BITS (LINE_WIDTH_BITS)
    ) u_io_ctrl (
        .mclk                  (mclk),
        .rst                   (rst),
        .wb_i                  (wb_i),
        .pad_stat_i            (pad_stat),
        .wb_o                  (wb_o),
        .cfg_o                 (cfg),
        .line_width_m1_o       (line_width_m1),
        .line_width_internal_o (line_width_internal)
    );

    sens_pad_ctrl u_pad_ctrl (
        .mclk           (mclk),
        .rst            (rst),
        .cfg_i          (cfg),
        .trigger_mode_i (trigger_mode_i),
        .trig_i         (trig_i),
        .mrst_i         (mrst_i),
        .senspgm_i      (senspgm_i),
        .tdo_i          (pxd_i[1]),  // tdo shares pixel bit 1
        .pad_stat_o     (pad_stat),
        .mrst_o         (mrst_o),
        .mrst_oe_o      (mrst_oe_o),
        .arst_o         (arst_o),
        .aro_o          (aro_o),
        .senspgm_o      (senspgm_o),
        .senspgm_oe_o   (senspgm_oe_o),
        .pxd0_o         (pxd0_o),
        .pxd0_oe_o      (pxd0_oe_o)
    );

    sens_line_timing #(
        .LINE_WIDTH_BITS (LINE_WIDTH_BITS)
    ) u_line_timing (
        .mclk                  (mclk),
        .rst                   (rst),
        .pxd_i                 (pxd_i),
        .hact_i                (hact_i),
        .vact_i                (vact_i),
        .line_width_m1_i       (line_width_m1),
        .line_width_internal_i (line_width_internal),
        .pxd_o                 (pxd_o),
        .hact_o                (hact_o),
        .vact_o                (vact_o)
    );

endmodule

`default_nettype wire

//--- sim/tb_sens_checks.svh
// Reference models and compare tasks for the sensor port testbench.
// Included inside the testbench module, after the package import.
`ifndef TB_SENS_CHECKS_SVH
`define TB_SENS_CHECKS_SVH

typedef struct packed {
    logic mrst;
    logic mrst_oe;
    logic arst;
    logic aro;
    logic senspgm;
    logic senspgm_oe;
    logic pxd0;
    logic pxd0_oe;
} pad_out_t;

// pair k of a write word: value in bit 2k, enable in bit 2k+1
function automatic logic pair_upd(input logic [31:0] w, input int k, input logic cur);
    return w[2*k+1] ? w[2*k] : cur;
endfunction

function automatic sens_cfg_t model_ctrl_wr(input sens_cfg_t c, input logic [31:0] w);
    sens_cfg_t n;
    n = c;
    n.mrst = pair_upd(w, 0, c.mrst);
    n.arst = pair_upd(w, 1, c.arst);
    n.aro  = pair_upd(w, 2, c.aro);
    return n;
endfunction

function automatic sens_cfg_t model_jtag_wr(input sens_cfg_t c, input logic [31:0] w);
    sens_cfg_t n;
    n = c;
    n.tdi   = pair_upd(w, 0, c.tdi);
    n.tms   = pair_upd(w, 1, c.tms);
    n.tck   = pair_upd(w, 2, c.tck);
    n.prog  = pair_upd(w, 3, c.prog);
    n.pgmen = pair_upd(w, 4, c.pgmen);
    return n;
endfunction

// expected pads from model register state, trigger inputs and probe level
function automatic pad_out_t exp_pads(input sens_cfg_t c, input logic tmode,
                                      input logic trig, input logic frc);
    pad_out_t p;
    p.mrst       = c.mrst;
    p.mrst_oe    = !c.pgmen;                      // released for DONE
    p.arst       = c.pgmen ? c.tms : c.arst;
    p.aro        = c.pgmen ? c.tck : (tmode ? !trig : c.aro);
    p.senspgm    = c.pgmen ? !c.prog : frc;
    p.senspgm_oe = c.pgmen | frc;
    p.pxd0       = c.tdi;
    p.pxd0_oe    = c.pgmen;
    return p;
endfunction

function automatic logic [31:0] exp_status(input pad_stat_t s, input logic pgmen,
                                           input logic int_hact);
    return {26'd0, int_hact, pgmen, s.force_pgm, s.done, s.senspgm_in, s.tdo};
endfunction

task automatic fail_stop(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
endtask

task automatic check_rsp(input string name, input wb_rsp_t act, input logic [31:0] exp);
    if (act.dat !== exp) begin
        fail_stop($sformatf("ERROR time=%0t %s exp=%h act=%h", $time, name, exp, act.dat));
    end
endtask

task automatic check_pads(input pad_out_t exp, input pad_out_t act);
    if (act !== exp) begin
        fail_stop($sformatf("ERROR time=%0t pads(mrst,oe,arst,aro,spgm,oe,pxd0,oe) exp=%b act=%b",
                            $time, exp, act));
    end
endtask

task automatic check_pixel(input logic [PXD_BITS-1:0] exp, input logic [PXD_BITS-1:0] act);
    if (act !== exp) begin
        fail_stop($sformatf("ERROR time=%0t pxd_o exp=%h act=%h", $time, exp, act));
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        fail_stop($sformatf("ERROR time=%0t %s exp=%b act=%b", $time, name, exp, act));
    end
endtask

`endif

//--- sim/tb_sens_parallel.sv
// Testbench for the parallel sensor port top level.
// Runs Wishbone register accesses, pad input patterns and line timing,
// and compares pads, status reads and pixel outputs with reference models.
`timescale 1ns/1ps
`default_nettype none

module tb_sens_parallel;
    import sens_io_pkg::*;
    `include "tb_sens_checks.svh"

    localparam int LW_BITS        = 16;
    localparam int TIMEOUT_CYCLES = 4000; // sequences take about 1100 cycles

    logic                mclk;
    logic                rst;
    wb_req_t             wb_req;
    wb_rsp_t             wb_rsp;
    logic                trigger_mode_i;
    logic                trig_i;
    logic [PXD_BITS-1:0] pxd_i;
    logic                hact_i;
    logic                vact_i;
    logic                mrst_i;
    logic                senspgm_i;
    logic [PXD_BITS-1:0] pxd_o;
    logic                hact_o, vact_o;
    logic                mrst_o, mrst_oe_o, arst_o, aro_o;
    logic                senspgm_o, senspgm_oe_o, pxd0_o, pxd0_oe_o;
    pad_out_t            pads_act;
    sens_cfg_t           mcfg;     // model register state
    logic                mforce;   // model force_pgm
    logic                mint;     // model internal hact flag
    logic [PXD_BITS-1:0] pxd_s;    // inputs seen at last edge
    logic                vact_s, hact_s;
    logic                ext_chk;  // compare hact_o against delayed hact_i
    logic                pix_rand; // random pixel/vact each cycle
    int                  cycles = 0;
    int                  seed;

    sens_parallel_top #(.LINE_WIDTH_BITS(LW_BITS)) dut (
        .mclk(mclk), .rst(rst), .wb_i(wb_req), .wb_o(wb_rsp),
        .trigger_mode_i(trigger_mode_i), .trig_i(trig_i),
        .pxd_i(pxd_i), .hact_i(hact_i), .vact_i(vact_i),
        .mrst_i(mrst_i), .senspgm_i(senspgm_i),
        .pxd_o(pxd_o), .hact_o(hact_o), .vact_o(vact_o),
        .mrst_o(mrst_o), .mrst_oe_o(mrst_oe_o), .arst_o(arst_o), .aro_o(aro_o),
        .senspgm_o(senspgm_o), .senspgm_oe_o(senspgm_oe_o),
        .pxd0_o(pxd0_o), .pxd0_oe_o(pxd0_oe_o)
    );

    assign pads_act = {mrst_o, mrst_oe_o, arst_o, aro_o,
                       senspgm_o, senspgm_oe_o, pxd0_o, pxd0_oe_o};

    always #50 mclk = ~mclk;

    always @(posedge mclk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_stop($sformatf("timeout: tests did not finish in %0d cycles", TIMEOUT_CYCLES));
        end
    end

    always @(posedge mclk) begin
        #1;
        if (pix_rand) begin
            pxd_i  = PXD_BITS'($random(seed));
            vact_i = 1'($random(seed));
        end
    end

    always @(posedge mclk) begin
        pxd_s  <= pxd_i;
        vact_s <= vact_i;
        hact_s <= hact_i;
    end

    // one-cycle pixel path check, outputs settled at the falling edge
    always @(negedge mclk) begin
        if (!rst) begin
            check_pixel(pxd_s, pxd_o);
            check_bit("vact_o", vact_s, vact_o);
            if (ext_chk) begin
                check_bit("hact_o", hact_s, hact_o);
            end
        end
    end

    task automatic wait_drive_slot();
        @(posedge mclk);
        #1;
    endtask

    task automatic wb_access(input logic we, input sens_reg_e adr, input logic [31:0] dat,
                             output wb_rsp_t rsp);
        wait_drive_slot();
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        do @(negedge mclk); while (!wb_rsp.ack);
        rsp = wb_rsp;
        wait_drive_slot();                    // request still up on this edge
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
        @(negedge mclk);
        check_bit("wb_o.ack", 1'b0, wb_rsp.ack); // single ack only
    endtask

    task automatic wb_write(input sens_reg_e adr, input logic [31:0] dat);
        wb_rsp_t rsp;
        wb_access(1'b1, adr, dat, rsp);
    endtask

    task automatic wb_read(input sens_reg_e adr, output wb_rsp_t rsp);
        wb_access(1'b0, adr, 32'h0, rsp);
    endtask

    task automatic check_pad_state();
        check_pads(exp_pads(mcfg, trigger_mode_i, trig_i, mforce), pads_act);
    endtask

    // STATUS read against the held pad inputs and the model flags
    task automatic read_status_check();
        wb_rsp_t   rsp;
        pad_stat_t st;
        st.done       = mrst_i;
        st.senspgm_in = senspgm_i;
        st.tdo        = pxd_i[1];
        st.force_pgm  = mforce;
        wb_read(REG_STATUS, rsp);
        check_rsp("STATUS", rsp, exp_status(st, mcfg.pgmen, mint));
    endtask

    task automatic drive_hact(input logic level, input int n_cyc);
        repeat (n_cyc) begin
            wait_drive_slot();
            hact_i = level;
        end
    endtask

    task automatic run_reg_test(input sens_reg_e adr, input int n, input logic pgm_on);
        logic [31:0] w;
        repeat (n) begin
            w = $random(seed);
            if (pgm_on) begin
                w[9:8] = 2'b11;                // keep pgmen set
            end
            wait_drive_slot();
            trigger_mode_i = 1'($random(seed));
            trig_i         = 1'($random(seed));
            wb_write(adr, w);
            mcfg = (adr == REG_CTRL) ? model_ctrl_wr(mcfg, w) : model_jtag_wr(mcfg, w);
            check_pad_state();
            if (pgm_on) begin
                check_bit("mrst_oe_o", 1'b0, mrst_oe_o);
            end
        end
    endtask

    task automatic run_probe_test();
        logic [31:0] w;
        repeat (4) begin
            w = $random(seed);
            w[9:8] = 2'b11;
            wb_write(REG_JTAG, w);
            mcfg = model_jtag_wr(mcfg, w);
            check_pad_state();
            wait_drive_slot();
            mrst_i    = 1'($random(seed));
            senspgm_i = 1'($random(seed));
            pxd_i[1]  = 1'($random(seed));       // tdo
            repeat (2) @(posedge mclk);
            read_status_check();
            wb_write(REG_JTAG, 32'h200);         // clear pgmen only
            mcfg   = model_jtag_wr(mcfg, 32'h200);
            mforce = senspgm_i;                  // probed on the fall
            repeat (3) @(posedge mclk);
            read_status_check();
            check_pad_state();
        end
    endtask

    task automatic run_int_hact_test();
        wb_rsp_t rsp;
        int      width;
        int      first;
        int      last;
        int      cnt;
        repeat (8) begin
            width = 1 + ({$random(seed)} % 40);
            wb_write(REG_WIDTH, width);
            mint = 1'b1;
            wb_read(REG_WIDTH, rsp);
            check_rsp("WIDTH", rsp, width);
            first = -1;
            last  = -1;
            cnt   = 0;
            for (int i = 0; i < width + 12; i++) begin
                wait_drive_slot();
                hact_i = (i < width + 3);          // longer than the width
                @(negedge mclk);
                if (hact_o) begin
                    if (first < 0) begin
                        first = i;
                    end
                    last = i;
                    cnt++;
                end
            end
            if (cnt != width) begin
                fail_stop($sformatf("ERROR time=%0t hact_o high cycles exp=%0d act=%0d",
                                    $time, width, cnt));
            end
            if (first != 1 || last != width) begin
                fail_stop("hact_o pulse did not start one cycle after hact_i as one run");
            end
        end
    endtask

    task automatic run_ext_hact_test();
        wb_write(REG_WIDTH, 32'h0);
        mint = 1'b0;
        wait_drive_slot();
        ext_chk = 1'b1;
        repeat (12) begin
            drive_hact(1'b1, 1 + ({$random(seed)} % 20));
            drive_hact(1'b0, 1 + ({$random(seed)} % 6));
        end
        repeat (3) @(negedge mclk);
        ext_chk = 1'b0;
    endtask

    initial begin
        seed           = 32'h11c23182;
        mclk           = 1'b0;
        rst            = 1'b1;
        wb_req         = '0;
        trigger_mode_i = 1'b0;
        trig_i         = 1'b0;
        pxd_i          = '0;
        hact_i         = 1'b0;
        vact_i         = 1'b0;
        mrst_i         = 1'b0;
        senspgm_i      = 1'b0;
        mcfg           = '0;
        mforce         = 1'b0;
        mint           = 1'b0;
        ext_chk        = 1'b0;
        pix_rand       = 1'b0;
        repeat (5) @(negedge mclk);               // mid reset
        check_bit("wb_o.ack", 1'b0, wb_rsp.ack);
        check_pad_state();
        check_pixel('0, pxd_o);
        check_bit("hact_o", 1'b0, hact_o);
        check_bit("vact_o", 1'b0, vact_o);
        repeat (5) @(posedge mclk);               // 10 edges in reset
        #1 rst = 1'b0;
        repeat (5) begin
            @(negedge mclk);
            check_bit("wb_o.ack", 1'b0, wb_rsp.ack);
        end
        run_reg_test(REG_CTRL, 24, 1'b0);
        run_reg_test(REG_JTAG, 12, 1'b1);
        run_probe_test();
        wb_write(REG_WIDTH, 32'd1);
        mint = 1'b1;
        read_status_check();                      // internal hact flag set
        pix_rand = 1'b1;
        run_int_hact_test();
        run_ext_hact_test();
        pix_rand = 1'b0;
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+sim
common/sens_io_pkg.sv
hw/sens_io_ctrl/sens_io_ctrl.sv
hw/sens_pad_ctrl.sv
hw/sens_line_timing.sv
hw/sens_parallel_top.sv
sim/tb_sens_parallel.sv
